// ==== Makefile ====
# Verilator flow for the hello register block
TOP := tb_cl_hello

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module $(TOP) -f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
	  echo "simulation reported failure"; exit 1; \
	fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
verilog/cl_hello_pkg.sv
verilog/vled_ctrl.sv
verilog/hello_cmd_reg.sv
verilog/cl_ocl_regs.sv
verilog/cl_hello_top.sv
tests/cl_hello_sva.sv
tests/tb_cl_hello.sv

// ==== tests/cl_hello_patterns.hex ====
// Columns kind_addr_data_dip_expected
// Kind 01 writes, 02 reads and compares, 03 sets the DIP switches and checks vled
02_00000500_00000000_0000_00000000
03_00000000_00000000_FFFF_00000000
01_00000500_2ABC1234_0000_00000000
02_00000500_00000000_0000_2ABC1234
02_00000504_00000000_0000_00001234
03_00000000_00000000_F0F0_00001030
01_00000500_F1234567_0000_00000000
02_00000500_00000000_0000_91234567
01_00000500_E00000FF_0000_00000000
02_00000500_00000000_0000_800000FF
01_00000500_5000C3C3_0000_00000000
03_00000000_00000000_0FF0_000003C0
01_00000504_FFFFFFFF_0000_00000000
01_00000608_12345678_0000_00000000
02_00000500_00000000_0000_5000C3C3
02_00000504_00000000_0000_0000C3C3
02_00000608_00000000_0000_DEADBEEF
01_00000500_7FFFFFFF_0000_00000000
02_00000500_00000000_0000_7FFFFFFF
03_00000000_00000000_A5A5_0000A5A5

// ==== tests/cl_hello_sva.sv ====
//--------------------
// AXI-Lite response channel checks, bound into the register slave
// Inactive while reset is low
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cl_hello_sva
  import cl_hello_pkg::*;
(
  input logic      clk_main_a0,
  input logic      rst_main_n_sync,
  input axil_req_t axil_req,
  input axil_rsp_t axil_rsp
);

  // B held until bready, then dropped
  a_b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid)
    else $error("write response dropped before bready");

  a_b_single: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    axil_rsp.bvalid && axil_req.bready |=> !axil_rsp.bvalid)
    else $error("second write response right after handshake");

  // R held with frozen data until rready
  a_r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
    else $error("read response dropped or changed before rready");

  a_r_single: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    axil_rsp.rvalid && axil_req.rready |=> !axil_rsp.rvalid)
    else $error("second read response right after handshake");

  // Response codes always OKAY
  a_resp_okay: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    axil_rsp.bresp == 2'b00 && axil_rsp.rresp == 2'b00)
    else $error("non zero response code");

endmodule

bind cl_ocl_regs cl_hello_sva sva_i (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .axil_req        (axil_req),
  .axil_rsp        (axil_rsp)
);

`default_nettype wire

// ==== tests/tb_cl_hello.sv ====
//--------------------
// Testbench for the hello register block
// Must run from the project root to find tests/cl_hello_patterns.hex
// B and R ready delays are random in 0 to 7 cycles
//--------------------
`timescale 1ns/1ps
`default_nettype none

module tb_cl_hello
  import cl_hello_pkg::*;
();

  localparam int RST_CYCLES     = 10;
  localparam int MAX_PAT        = 64;
  localparam int CYCLES_PER_PAT = 40;

  // One pattern line of 120 bits
  typedef struct packed {
    logic [7:0] kind;
    axil_addr_t addr;
    axil_data_t data;
    led_t       dip;
    axil_data_t expect_val;
  } pattern_t;

  logic         clk_main_a0;
  logic         rst_main_n_sync;
  axil_req_t    axil_req;
  axil_rsp_t    axil_rsp;
  led_t         vdip;
  led_t         vled;
  logic [119:0] pat_mem [0:MAX_PAT-1];
  int           pat_count = 0;
  int           err_count = 0;
  int           pass_count = 0;
  int           fail_count = 0;
  logic [31:0]  rng_state;

  cl_hello_top dut_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .vdip            (vdip),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #2 clk_main_a0 = ~clk_main_a0;
  end

  //--------------------
  // Helpers
  //--------------------
  // Next ready delay from the xorshift state
  function automatic logic [2:0] next_delay();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[2:0];
  endfunction

  // Inputs change 1 ns after the edge
  task automatic wait_cycle();
    @(posedge clk_main_a0);
    #1;
  endtask

  task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
    logic aw_hs;
    logic w_hs;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    // Address and data handshakes sampled mid cycle
    while (axil_req.awvalid || axil_req.wvalid) begin
      @(negedge clk_main_a0);
      aw_hs = axil_req.awvalid && axil_rsp.awready;
      w_hs  = axil_req.wvalid && axil_rsp.wready;
      wait_cycle();
      if (aw_hs)
        axil_req.awvalid = 1'b0;
      if (w_hs)
        axil_req.wvalid = 1'b0;
    end
    repeat (next_delay()) wait_cycle();
    axil_req.bready = 1'b1;
    @(negedge clk_main_a0);
    while (!axil_rsp.bvalid)
      @(negedge clk_main_a0);
    if (axil_rsp.bresp !== 2'b00) begin
      $display("mismatch bresp at %h: got %h expected %h", addr, axil_rsp.bresp, 2'b00);
      err_count++;
    end
    // Write still open until B is taken
    if (axil_rsp.awready !== 1'b0) begin
      $display("mismatch awready at %h: got %h expected %h", addr, axil_rsp.awready, 1'b0);
      err_count++;
    end
    wait_cycle();
    axil_req.bready = 1'b0;
    @(negedge clk_main_a0);
    if (axil_rsp.bvalid !== 1'b0) begin
      $display("write response at %h still valid after it was accepted", addr);
      err_count++;
    end
    wait_cycle();
  endtask

  task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
    logic ar_hs;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    ar_hs = 1'b0;
    while (!ar_hs) begin
      @(negedge clk_main_a0);
      ar_hs = axil_rsp.arready;
      wait_cycle();
    end
    axil_req.arvalid = 1'b0;
    repeat (next_delay()) wait_cycle();
    axil_req.rready = 1'b1;
    @(negedge clk_main_a0);
    while (!axil_rsp.rvalid)
      @(negedge clk_main_a0);
    data = axil_rsp.rdata;
    if (axil_rsp.rresp !== 2'b00) begin
      $display("mismatch rresp at %h: got %h expected %h", addr, axil_rsp.rresp, 2'b00);
      err_count++;
    end
    // No new read address while R waits
    if (axil_rsp.arready !== 1'b0) begin
      $display("mismatch arready at %h: got %h expected %h", addr, axil_rsp.arready, 1'b0);
      err_count++;
    end
    wait_cycle();
    axil_req.rready = 1'b0;
    @(negedge clk_main_a0);
    if (axil_rsp.rvalid !== 1'b0) begin
      $display("read response at %h still valid after it was accepted", addr);
      err_count++;
    end
    wait_cycle();
  endtask

  // DIP to vled is 3 cycles
  task automatic check_led(input led_t dip, input led_t exp_led);
    vdip = dip;
    repeat (3) wait_cycle();
    @(negedge clk_main_a0);
    if (vled !== exp_led) begin
      $display("mismatch vled: got %h expected %h", vled, exp_led);
      err_count++;
    end
    wait_cycle();
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail", name);
    end
  endtask

  //--------------------
  // Main sequence
  //--------------------
  initial begin : main_flow
    pattern_t   pat;
    axil_data_t rd_val;
    int         errs_before;
    axil_req        = '0;
    vdip            = '0;
    rst_main_n_sync = 1'b0;
    rng_state       = 32'd28095;
    for (int i = 0; i < MAX_PAT; i++)
      pat_mem[i] = '0;
    $readmemh("tests/cl_hello_patterns.hex", pat_mem);
    // Kind zero marks the end of the list
    while (pat_count < MAX_PAT && pat_mem[pat_count][119:112] != 8'h00)
      pat_count++;
    if (pat_count == 0) begin
      $display("no patterns loaded from tests/cl_hello_patterns.hex");
      fail_count++;
    end
    repeat (RST_CYCLES) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
    // State right after reset
    errs_before = err_count;
    @(negedge clk_main_a0);
    if (vled !== 16'h0000) begin
      $display("mismatch vled: got %h expected %h", vled, 16'h0000);
      err_count++;
    end
    if (axil_rsp.bvalid !== 1'b0 || axil_rsp.rvalid !== 1'b0) begin
      $display("response valid high right after reset");
      err_count++;
    end
    wait_cycle();
    report_test("reset state", errs_before);
    for (int i = 0; i < pat_count; i++) begin
      pat = pat_mem[i];
      errs_before = err_count;
      case (pat.kind)
        8'h01: write_reg(pat.addr, pat.data);
        8'h02: begin
          read_reg(pat.addr, rd_val);
          if (rd_val !== pat.expect_val) begin
            $display("mismatch rdata at %h: got %h expected %h", pat.addr, rd_val,
                     pat.expect_val);
            err_count++;
          end
        end
        8'h03: check_led(pat.dip, pat.expect_val[15:0]);
        default: begin
          $display("pattern %0d has an unknown kind %h", i, pat.kind);
          err_count++;
        end
      endcase
      report_test($sformatf("pattern %0d kind %0h addr %h", i, pat.kind, pat.addr),
                  errs_before);
    end
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Watchdog sized from the pattern count
  initial begin : watchdog
    wait (pat_count != 0);
    repeat (pat_count * CYCLES_PER_PAT + RST_CYCLES) @(posedge clk_main_a0);
    $display("timeout after %0d cycles, run did not finish",
             pat_count * CYCLES_PER_PAT + RST_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cl_hello_pkg.sv ====
//--------------------
// Shared widths, register map and bus structs for the hello block
// AXI-Lite is single beat and write strobes are not carried
// Response codes are always OKAY
//--------------------
`default_nettype none

package cl_hello_pkg;

  // Widths with a meaning
  typedef logic [31:0] axil_addr_t;
  typedef logic [31:0] axil_data_t;
  typedef logic [1:0]  axil_resp_t;
  typedef logic [15:0] led_t;
  typedef logic [27:0] cmd_id_t;

  // Register map defaults, overridden from the top level
  localparam axil_addr_t HELLO_ADDR_DEF = 32'h0000_0500;
  localparam axil_addr_t VLED_ADDR_DEF  = 32'h0000_0504;
  localparam axil_data_t UNIMPL_VALUE   = 32'hDEAD_BEEF;

  // Command opcodes, codes 4 to 7 all fold into MSC
  typedef enum logic [2:0] {
    DEL = 3'd0,
    ADD = 3'd1,
    SET = 3'd2,
    RDC = 3'd3,
    MSC = 3'd4
  } opcode_t;

  // Same bit layout as the command register word
  typedef struct packed {
    opcode_t opcode;
    logic    mode;
    cmd_id_t id;
  } hello_cmd_t;

  // Master driven side
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // Slave driven side
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/cl_hello_top.sv ====
//--------------------
// Hello register block top level
// Reset must arrive already synchronous to clk_main_a0
// Register addresses set here and passed to the slave
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cl_hello_top
  import cl_hello_pkg::*;
#(
  parameter axil_addr_t HELLO_ADDR = HELLO_ADDR_DEF,
  parameter axil_addr_t VLED_ADDR  = VLED_ADDR_DEF
) (
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  led_t      vdip,
  output led_t      vled
);

  // Internal links
  logic       cmd_wr;
  axil_data_t cmd_wdata;
  hello_cmd_t cmd;
  led_t       led_shadow;

  // Bus slave and register decode
  cl_ocl_regs #(
    .HELLO_ADDR (HELLO_ADDR),
    .VLED_ADDR  (VLED_ADDR)
  ) ocl_regs_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .axil_req        (axil_req),
    .axil_rsp        (axil_rsp),
    .cmd_wr          (cmd_wr),
    .cmd_wdata       (cmd_wdata),
    .cmd             (cmd),
    .led_shadow      (led_shadow)
  );

  // Command storage
  hello_cmd_reg cmd_reg_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd_wr          (cmd_wr),
    .cmd_wdata       (cmd_wdata),
    .cmd             (cmd)
  );

  // LED shadow and DIP mask
  vled_ctrl vled_ctrl_i (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cmd             (cmd),
    .vdip            (vdip),
    .led_shadow      (led_shadow),
    .vled            (vled)
  );

endmodule

`default_nettype wire

// ==== verilog/cl_ocl_regs.sv ====
//--------------------
// AXI-Lite register slave, one write and one read in flight at most
// Writes outside HELLO_ADDR are accepted and dropped
// Unmapped reads return UNIMPL_VALUE with an OKAY response
//--------------------
`timescale 1ns/1ps
`default_nettype none

module cl_ocl_regs
  import cl_hello_pkg::*;
#(
  parameter axil_addr_t HELLO_ADDR = HELLO_ADDR_DEF,
  parameter axil_addr_t VLED_ADDR  = VLED_ADDR_DEF
) (
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  axil_req_t  axil_req,
  output axil_rsp_t  axil_rsp,
  output logic       cmd_wr,
  output axil_data_t cmd_wdata,
  input  hello_cmd_t cmd,
  input  led_t       led_shadow
);

  //--------------------
  // Write channel
  //--------------------
  logic       wr_active;
  axil_addr_t wr_addr;
  logic       awready;
  logic       wready;
  logic       bvalid;
  logic       aw_hs;

  // Address accepted only when no write is open
  assign awready = !wr_active;
  assign aw_hs   = axil_req.awvalid && awready;
  // Data taken once per write, blocked while B is waiting
  assign wready  = wr_active && axil_req.wvalid && !bvalid;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (bvalid && axil_req.bready) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end
  end

  // Captured write address
  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr <= axil_req.awaddr;
    end
  end

  // B rises the cycle after the data beat, held until bready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && axil_req.bready) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end
  end

  // Command strobe on the data beat
  assign cmd_wr    = wready && (wr_addr == HELLO_ADDR);
  assign cmd_wdata = axil_req.wdata;

  //--------------------
  // Read channel
  //--------------------
  logic       rd_pend;
  axil_addr_t rd_addr;
  logic       arready;
  logic       ar_hs;
  logic       rvalid;
  axil_data_t rdata;
  axil_data_t rd_mux;

  // No new address until R has been taken
  assign arready = !rd_pend && !rvalid;
  assign ar_hs   = axil_req.arvalid && arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend <= 1'b0;
    end else begin
      rd_pend <= ar_hs;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr <= axil_req.araddr;
    end
  end

  // Read data select
  always_comb begin
    if (rd_addr == HELLO_ADDR) begin
      rd_mux = axil_data_t'(cmd);
    end else if (rd_addr == VLED_ADDR) begin
      rd_mux = {16'h0000, led_shadow};
    end else begin
      rd_mux = UNIMPL_VALUE;
    end
  end

  // R one cycle after the address, data frozen while held
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rd_pend) begin
      rvalid <= 1'b1;
    end else if (rvalid && axil_req.rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (rd_pend) begin
      rdata <= rd_mux;
    end
  end

  // Response bundle
  always_comb begin
    axil_rsp.awready = awready;
    axil_rsp.wready  = wready;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = 2'b00;
    axil_rsp.arready = arready;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = 2'b00;
  end

endmodule

`default_nettype wire

// ==== verilog/hello_cmd_reg.sv ====
//--------------------
// Command register with opcode decode
// Codes 4 to 7 are stored as MSC, so reads see them as 4
//--------------------
`timescale 1ns/1ps
`default_nettype none

module hello_cmd_reg
  import cl_hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       cmd_wr,
  input  axil_data_t cmd_wdata,
  output hello_cmd_t cmd
);

  opcode_t opc_dec;

  // Top three data bits to opcode
  always_comb begin
    case (cmd_wdata[31:29])
      3'd0:    opc_dec = DEL;
      3'd1:    opc_dec = ADD;
      3'd2:    opc_dec = SET;
      3'd3:    opc_dec = RDC;
      default: opc_dec = MSC;
    endcase
  end

  //--------------------
  // Storage
  //--------------------
  // Updated on the edge after the strobe cycle
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      cmd.opcode <= DEL;
      cmd.mode   <= 1'b0;
      cmd.id     <= '0;
    end else if (cmd_wr) begin
      cmd.opcode <= opc_dec;
      cmd.mode   <= cmd_wdata[28];
      cmd.id     <= cmd_wdata[27:0];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vled_ctrl.sv ====
//--------------------
// Virtual LED path
// DIP to vled takes 3 cycles and cmd to vled takes 2
//--------------------
`timescale 1ns/1ps
`default_nettype none

module vled_ctrl
  import cl_hello_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  hello_cmd_t cmd,
  input  led_t       vdip,
  output led_t       led_shadow,
  output led_t       vled
);

  // Two stage synchronizer for the DIP switches
  led_t vdip_q1;
  led_t vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1 <= '0;
      vdip_q2 <= '0;
    end else begin
      vdip_q1 <= vdip;
      vdip_q2 <= vdip_q1;
    end
  end

  //--------------------
  // Shadow and output
  //--------------------
  // Shadow follows the low half of the command word
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      led_shadow <= '0;
      vled       <= '0;
    end else begin
      led_shadow <= cmd.id[15:0];
      // Masked by synchronized DIP bits
      vled       <= led_shadow & vdip_q2;
    end
  end

endmodule

`default_nettype wire
